// File: vlog.f
verilog/i2s_rx_pkg.sv
verilog/i2s_reg_if.sv
verilog/ahbl_reg_decode.sv
verilog/i2s_deserializer.sv
verilog/sample_fifo.sv
verilog/i2s_rx_regs.sv
verilog/ahbl_i2s_rx.sv
testbench/i2s_rx_props.sv
testbench/tb_ahbl_i2s_rx.sv

// File: Makefile
SRCS := $(wildcard verilog/*.sv testbench/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_ahbl_i2s_rx
	@out="$$(./obj_dir/Vtb_ahbl_i2s_rx)"; status=$$?; echo "$$out"; \
	test $$status -eq 0 && echo "$$out" | grep -q "All tests passed"

obj_dir/Vtb_ahbl_i2s_rx: vlog.f $(SRCS)
	verilator --binary --timing --assert -f vlog.f \
		--top-module tb_ahbl_i2s_rx -o Vtb_ahbl_i2s_rx

clean:
	rm -rf obj_dir

// File: testbench/tb_ahbl_i2s_rx.sv
`timescale 1ns/100ps

module tb_ahbl_i2s_rx import i2s_rx_pkg::*; ();

    localparam int N_FRAMES = 64;
    localparam logic [31:0] SEED = 32'h441737f0;
    localparam realtime TIMEOUT = N_FRAMES * FRAME_BITS * 2 * SCK_DIV * 100.0 * 3 + 500000.0;

    logic HCLK, HRESETn, HWRITE, HSEL, HREADY, HREADYOUT, SD, SCK, WS, IRQ;
    logic [31:0] HADDR, HWDATA, HRDATA;
    logic [1:0]  HTRANS;
    logic [2:0]  HSIZE;

    logic [31:0] lfsr = SEED;
    logic [31:0] model_q [$];    // Reference FIFO
    logic        model_ovf = 1'b0;
    logic        model_rearm = 1'b1;
    int          exp_irq = 0;
    int          irq_count = 0;
    logic        pop_at_edge = 1'b0;  // Model popped ahead of the DUT edge
    logic        tx_on = 1'b0;
    logic        sck_d = 1'b0, ws_d = 1'b0, ws_fell;
    logic [31:0] tx_word = '0, pend_word = '0, commit_word = '0;
    logic        pend_valid = 1'b0, commit_valid = 1'b0;
    logic [31:0] rd;
    event        committed;

    ahbl_i2s_rx UUT (.*);

    initial begin
        HCLK = 1'b0;
        forever #50 HCLK = ~HCLK;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [15:0] rand16();
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic ahb_write(input logic [7:0] off, input logic [31:0] data);
        @(posedge HCLK);
        HSEL   <= 1'b1;
        HTRANS <= 2'b10;
        HWRITE <= 1'b1;
        HADDR  <= {24'h0, off};
        @(posedge HCLK);
        HSEL   <= 1'b0;
        HTRANS <= 2'b00;
        HWDATA <= data;
        @(posedge HCLK);
    endtask

    // Returns in the middle of the data phase
    task automatic ahb_read(input logic [7:0] off, output logic [31:0] data);
        @(posedge HCLK);
        HSEL   <= 1'b1;
        HTRANS <= 2'b10;
        HWRITE <= 1'b0;
        HADDR  <= {24'h0, off};
        @(posedge HCLK);
        HSEL   <= 1'b0;
        HTRANS <= 2'b00;
        @(negedge HCLK);
        data = HRDATA;
        check_value("HREADYOUT", 32'(HREADYOUT), 32'h1);
    endtask

    function automatic logic [31:0] model_status();
        int n;
        n = model_q.size();
        return (n << 8) | (32'(model_ovf) << 2) | (32'(n == 16) << 1) | 32'(n == 0);
    endfunction

    task automatic check_status();
        ahb_read(STATUS_OFF, rd);
        check_value("STATUS", rd, model_status());
    endtask

    // Read words until the model and the DUT are both empty
    task automatic drain();
        forever begin
            check_status();
            if (model_q.size() == 0)
                break;
            ahb_read(DATA_OFF, rd);
            check_value("DATA", rd, model_q[0]);
            void'(model_q.pop_front());
            pop_at_edge = 1'b1;
            if (model_q.size() == 0)
                model_rearm = 1'b1;
        end
    endtask

    task automatic idle_pins(input int cycles);
        repeat (cycles) begin
            @(negedge HCLK);
            check_value("SCK", 32'(SCK), 32'h0);
            check_value("WS", 32'(WS), 32'h0);
        end
    endtask

    // I2S transmitter and model update, SCK edges seen one HCLK late
    always @(posedge HCLK) begin
        if (!tx_on) begin
            pend_valid   = 1'b0;
            commit_valid = 1'b0;
        end else if (sck_d && !SCK) begin
            ws_fell = ws_d && !WS;
            SD <= tx_word[31];            // Right LSB first at a frame start
            if (ws_fell) begin
                commit_valid = pend_valid;
                commit_word  = pend_word;
                pend_word    = {rand16(), rand16()};
                pend_valid   = 1'b1;
                tx_word      = pend_word;
            end else begin
                tx_word = tx_word << 1;
            end
        end else if (!sck_d && SCK && commit_valid) begin
            commit_valid = 1'b0;          // Same edge as the DUT push
            if (model_q.size() + int'(pop_at_edge) >= 16) begin
                model_ovf = 1'b1;
            end else begin
                model_q.push_back(commit_word);
                if (model_q.size() == 16 && model_rearm) begin
                    exp_irq++;
                    model_rearm = 1'b0;
                end
            end
            -> committed;
        end
        sck_d       = SCK;
        ws_d        = WS;
        pop_at_edge = 1'b0;
        if (IRQ)
            irq_count++;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish in the expected time");
        $display("Some tests failed");
        $fatal(1, "watchdog");
    end

    initial begin
        HRESETn = 1'b0;
        HADDR = '0;
        HTRANS = 2'b00;
        HWRITE = 1'b0;
        HSIZE = SIZE_WORD;
        HWDATA = '0;
        HSEL = 1'b0;
        HREADY = 1'b1;
        SD = 1'b0;
        repeat (2) @(posedge HCLK);
        HRESETn <= 1'b1;

        // Reset state
        ahb_read(CTRL_OFF, rd);
        check_value("CTRL", rd, 32'h0);
        check_status();
        idle_pins(10);
        ahb_read(8'h0C, rd);
        check_value("unmapped read", rd, BAD_READ);
        ahb_read(DATA_OFF, rd);
        check_value("DATA", rd, 32'h0);   // Empty FIFO reads as zero
        check_status();

        // Enable, flush bit reads back 0
        tx_on = 1'b1;
        ahb_write(CTRL_OFF, 32'h3);
        ahb_read(CTRL_OFF, rd);
        check_value("CTRL", rd, 32'h1);

        // Streaming capture
        repeat (6) @(committed);
        drain();

        // Fill, overflow and interrupt
        while (model_q.size() < 16)
            @(committed);
        repeat (4) @(posedge HCLK);
        check_value("IRQ count", irq_count, exp_irq);
        repeat (3) @(committed);
        check_status();
        check_value("IRQ count", irq_count, 1);
        drain();
        while (model_q.size() < 16)
            @(committed);
        repeat (4) @(posedge HCLK);
        check_value("IRQ count", irq_count, 2);
        @(committed);
        ahb_write(STATUS_OFF, 32'h4);
        model_ovf = 1'b0;
        check_status();
        drain();

        // Flush right after a frame lands
        repeat (3) @(committed);
        ahb_write(CTRL_OFF, 32'h3);
        model_q.delete();
        model_rearm = 1'b1;
        @(posedge HCLK);
        check_status();
        repeat (4) @(committed);
        drain();
        check_value("IRQ count", irq_count, exp_irq);

        // Disable, level holds
        repeat (2) @(committed);
        ahb_write(CTRL_OFF, 32'h0);
        tx_on = 1'b0;
        @(posedge HCLK);    // SCK and WS clear on the edge after enable drops
        idle_pins(8);
        check_status();
        idle_pins(300);
        check_status();

        $display("All tests passed");
        $finish;
    end

endmodule

// File: testbench/i2s_rx_props.sv
`timescale 1ns/100ps

module i2s_rx_props (
    input logic HCLK,
    input logic HRESETn,
    input logic IRQ,
    input logic push,
    input logic full,
    input logic flush
);

    // Interrupt is a single cycle pulse
    irq_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn) IRQ |=> !IRQ)
        else $error("IRQ high for two cycles");

    // A full FIFO never sees a push
    no_push_full: assert property (@(posedge HCLK) disable iff (!HRESETn) !(push && full))
        else $error("push while full");

    flush_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn) flush |=> !flush)
        else $error("flush high for two cycles");  // Self clearing bit

endmodule

bind i2s_rx_regs i2s_rx_props u_props (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .IRQ     (IRQ),
    .push    (push),
    .full    (full),
    .flush   (flush)
);

// File: verilog/ahbl_i2s_rx.sv
`timescale 1ns/100ps

module ahbl_i2s_rx import i2s_rx_pkg::*; (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  logic [ADDR_W-1:0] HADDR,
    input  logic [1:0]        HTRANS,
    input  logic              HWRITE,
    input  logic [2:0]        HSIZE,
    input  logic [DATA_W-1:0] HWDATA,
    input  logic              HSEL,
    input  logic              HREADY,
    output logic [DATA_W-1:0] HRDATA,
    output logic              HREADYOUT,

    input  logic              SD,
    output logic              SCK,
    output logic              WS,
    output logic              IRQ
);

    logic               en;
    logic               sample_valid;
    logic [DATA_W-1:0]  sample;
    logic               push;
    logic               pop;
    logic               flush;
    logic [DATA_W-1:0]  fifo_rdata;
    logic               empty;
    logic               full;
    logic [LEVEL_W-1:0] level;

    i2s_reg_if reg_bus ();

    ahbl_reg_decode u_decode (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HSIZE     (HSIZE),
        .HWDATA    (HWDATA),
        .HSEL      (HSEL),
        .HREADY    (HREADY),
        .HRDATA    (HRDATA),
        .HREADYOUT (HREADYOUT),
        .bus       (reg_bus.bus)
    );

    i2s_deserializer u_deser (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .en           (en),
        .SD           (SD),
        .SCK          (SCK),
        .WS           (WS),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    sample_fifo u_fifo (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .push    (push),
        .pop     (pop),
        .flush   (flush),
        .wdata   (sample),
        .rdata   (fifo_rdata),
        .empty   (empty),
        .full    (full),
        .level   (level)
    );

    i2s_rx_regs u_regs (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .regs         (reg_bus.regs),
        .sample_valid (sample_valid),
        .fifo_rdata   (fifo_rdata),
        .empty        (empty),
        .full         (full),
        .level        (level),
        .en           (en),
        .flush        (flush),
        .push         (push),
        .pop          (pop),
        .IRQ          (IRQ)
    );

endmodule

// File: verilog/i2s_rx_regs.sv
`timescale 1ns/100ps

module i2s_rx_regs import i2s_rx_pkg::*; (
    input  logic               HCLK,
    input  logic               HRESETn,

    i2s_reg_if.regs            regs,

    input  logic               sample_valid,
    input  logic [DATA_W-1:0]  fifo_rdata,
    input  logic               empty,
    input  logic               full,
    input  logic [LEVEL_W-1:0] level,

    output logic               en,
    output logic               flush,
    output logic               push,
    output logic               pop,
    output logic               IRQ
);

    logic en_q;
    logic flush_q;
    logic ovf_q;       // Sticky, a sample hit a full FIFO
    logic full_d;
    logic rearm;       // FIFO has been empty since the last IRQ
    logic irq_q;
    logic ctrl_wr;
    logic stat_wr;
    logic full_rise;

    assign ctrl_wr   = regs.wr & (regs.addr == CTRL_OFF);
    assign stat_wr   = regs.wr & (regs.addr == STATUS_OFF);
    assign full_rise = full & ~full_d;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            en_q    <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            if (ctrl_wr)
                en_q <= regs.wdata[CTRL_EN_BIT];
            flush_q <= ctrl_wr & regs.wdata[CTRL_FLUSH_BIT] & ~flush_q;  // Self clearing
        end
    end

    // A new overflow beats a clear in the same cycle
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn)
            ovf_q <= 1'b0;
        else if (sample_valid && full)
            ovf_q <= 1'b1;
        else if (stat_wr && regs.wdata[STAT_OVF_BIT])
            ovf_q <= 1'b0;
    end

    // One pulse per empty to full cycle
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            full_d <= 1'b0;
            rearm  <= 1'b1;
            irq_q  <= 1'b0;
        end else begin
            full_d <= full;
            irq_q  <= full_rise & rearm;
            if (empty)
                rearm <= 1'b1;
            else if (full_rise)
                rearm <= 1'b0;
        end
    end

    assign push = sample_valid & ~full;
    assign pop  = regs.rd & (regs.addr == DATA_OFF) & ~empty;  // Read of DATA pops the head

    always_comb begin
        regs.rdata = BAD_READ;
        case (regs.addr)
            CTRL_OFF:   regs.rdata = DATA_W'(en_q);   // Flush bit reads as 0
            STATUS_OFF: regs.rdata = DATA_W'({level, 5'b0, ovf_q, full, empty});
            DATA_OFF:   regs.rdata = empty ? '0 : fifo_rdata;
            default:    regs.rdata = BAD_READ;
        endcase
    end

    assign en    = en_q;
    assign flush = flush_q;
    assign IRQ   = irq_q;

endmodule

// File: verilog/sample_fifo.sv
`timescale 1ns/100ps

module sample_fifo import i2s_rx_pkg::*; (
    input  logic               HCLK,
    input  logic               HRESETn,
    input  logic               push,
    input  logic               pop,
    input  logic               flush,
    input  logic [DATA_W-1:0]  wdata,
    output logic [DATA_W-1:0]  rdata,
    output logic               empty,
    output logic               full,
    output logic [LEVEL_W-1:0] level
);

    logic [DATA_W-1:0]  mem [2**FIFO_AW];
    logic [FIFO_AW:0]   wr_ptr;    // Extra bit tells full from empty
    logic [FIFO_AW:0]   rd_ptr;
    logic               do_push;
    logic               do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign level = wr_ptr - rd_ptr;

    // Flush wins over both ports
    assign do_push = push & ~full & ~flush;
    assign do_pop  = pop & ~empty & ~flush;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge HCLK) begin
        if (do_push)
            mem[wr_ptr[FIFO_AW-1:0]] <= wdata;
    end

    // Show-ahead, the head word is always on rdata
    assign rdata = mem[rd_ptr[FIFO_AW-1:0]];

endmodule

// File: verilog/i2s_deserializer.sv
`timescale 1ns/100ps

module i2s_deserializer import i2s_rx_pkg::*; (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  logic              en,
    input  logic              SD,
    output logic              SCK,
    output logic              WS,
    output logic              sample_valid,
    output logic [DATA_W-1:0] sample
);

    logic [DIV_W-1:0]  div_cnt;
    logic              sck_q;
    logic [BIT_W-1:0]  bit_cnt;   // Slot within the frame, changes on SCK fall
    logic [DATA_W-1:0] shreg;
    logic              armed;     // WS has fallen at least once
    logic              primed;    // Left MSB of a real frame is in
    logic              half_done;
    logic              sck_rise;
    logic              sck_fall;
    logic              last_slot;

    assign half_done = (div_cnt == DIV_W'(SCK_DIV - 1));
    assign sck_rise  = en & half_done & ~sck_q;
    assign sck_fall  = en & half_done & sck_q;
    assign last_slot = (bit_cnt == BIT_W'(FRAME_BITS - 1));

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            div_cnt      <= '0;
            sck_q        <= 1'b0;
            bit_cnt      <= '0;
            armed        <= 1'b0;
            primed       <= 1'b0;
            sample_valid <= 1'b0;
        end else if (!en) begin
            div_cnt      <= '0;   // Hold SCK and WS low while disabled
            sck_q        <= 1'b0;
            bit_cnt      <= '0;
            armed        <= 1'b0;
            primed       <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            div_cnt <= half_done ? '0 : div_cnt + 1'b1;
            if (half_done)
                sck_q <= ~sck_q;

            if (sck_fall) begin
                bit_cnt <= last_slot ? '0 : bit_cnt + 1'b1;
                if (last_slot)
                    armed <= 1'b1;
            end

            // Slot 1 carries the left MSB because of the one bit delay
            if (sck_rise && bit_cnt == BIT_W'(1) && armed)
                primed <= 1'b1;

            // Right LSB arrives in slot 0 of the next frame
            sample_valid <= sck_rise & (bit_cnt == '0) & primed;
        end
    end

    // MSB first, so after 32 bits the register holds {left, right}
    always_ff @(posedge HCLK) begin
        if (sck_rise)
            shreg <= {shreg[DATA_W-2:0], SD};
    end

    assign SCK    = sck_q;
    assign WS     = bit_cnt[BIT_W-1];   // Low for left, high for right
    assign sample = shreg;

endmodule

// File: verilog/ahbl_reg_decode.sv
`timescale 1ns/100ps

module ahbl_reg_decode import i2s_rx_pkg::*; (
    input  logic              HCLK,
    input  logic              HRESETn,

    input  logic [ADDR_W-1:0] HADDR,
    input  logic [1:0]        HTRANS,
    input  logic              HWRITE,
    input  logic [2:0]        HSIZE,
    input  logic [DATA_W-1:0] HWDATA,
    input  logic              HSEL,
    input  logic              HREADY,

    output logic [DATA_W-1:0] HRDATA,
    output logic              HREADYOUT,

    i2s_reg_if.bus            bus
);

    logic             sel_q;    // Data phase belongs to this slave
    logic             write_q;
    logic [OFF_W-1:0] addr_q;
    logic             addr_hit;

    // NONSEQ and SEQ both have HTRANS[1] set
    assign addr_hit = HSEL & HTRANS[1] & (HSIZE == SIZE_WORD);

    // Address phase is sampled only when the previous transfer completes
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            sel_q   <= 1'b0;
            write_q <= 1'b0;
            addr_q  <= '0;
        end else if (HREADY) begin
            sel_q   <= addr_hit;
            write_q <= HWRITE;
            addr_q  <= HADDR[OFF_W-1:0];
        end
    end

    // Data phase strobes
    assign bus.wr    = sel_q & write_q;
    assign bus.rd    = sel_q & ~write_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = HWDATA;

    assign HRDATA    = bus.rdata;
    assign HREADYOUT = 1'b1;    // Zero wait states

endmodule

// File: verilog/i2s_reg_if.sv
`timescale 1ns/100ps

// One register access, valid in the AHB data phase
interface i2s_reg_if import i2s_rx_pkg::*; ();

    logic              wr;     // Write strobe, one cycle
    logic              rd;     // Read strobe, one cycle
    logic [OFF_W-1:0]  addr;   // Register offset
    logic [DATA_W-1:0] wdata;  // HWDATA of the data phase
    logic [DATA_W-1:0] rdata;  // Combinational read data

    // Bus side drives the access
    modport bus (
        output wr,
        output rd,
        output addr,
        output wdata,
        input  rdata
    );

    // Register side answers it
    modport regs (
        input  wr,
        input  rd,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// File: verilog/i2s_rx_pkg.sv
package i2s_rx_pkg;

    // Bus and sample word
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;            // AHB address width

    // Serial frame
    localparam int HALF_W     = 16;         // Bits per channel
    localparam int FRAME_BITS = 2 * HALF_W; // SCK periods per stereo frame
    localparam int BIT_W      = $clog2(FRAME_BITS);

    // Bit clock, HCLK cycles per SCK half period
    localparam int SCK_DIV = 2;
    localparam int DIV_W   = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;

    // Sample FIFO, 16 words deep
    localparam int FIFO_AW = 4;
    localparam int LEVEL_W = FIFO_AW + 1;   // Level counts 0 to 16 inclusive

    // Only word transfers reach the registers
    localparam logic [2:0] SIZE_WORD = 3'b010;

    // Register map
    localparam int OFF_W = 8;
    localparam logic [OFF_W-1:0] CTRL_OFF   = 8'h00;
    localparam logic [OFF_W-1:0] STATUS_OFF = 8'h04;
    localparam logic [OFF_W-1:0] DATA_OFF   = 8'h08;

    // CTRL and STATUS bit positions
    localparam int CTRL_EN_BIT    = 0;
    localparam int CTRL_FLUSH_BIT = 1;
    localparam int STAT_OVF_BIT   = 2;

    // Returned for offsets outside the map
    localparam logic [DATA_W-1:0] BAD_READ = 32'hBADDBEEF;

endpackage
